// ==== rtl/octavo_cfg.svh ====
// Width and I/O port map macros for the datapath, included by the package, the RTL and the testbench
`ifndef OCTAVO_CFG_SVH
`define OCTAVO_CFG_SVH

// ----------------------------------------
// Data and address widths

// One data word
`define OCTAVO_WORD_WIDTH 16

// Word address within a single bank, 64 words per bank
`define OCTAVO_ADDR_WIDTH 6

// Destination address, the top bit picks bank B over bank A
`define OCTAVO_WRITE_ADDR_WIDTH 7

// ----------------------------------------
// Memory-mapped I/O ports

// Ports per bank
`define OCTAVO_IO_PORT_COUNT 2

// Bank address of port 0, port p sits at base plus p
`define OCTAVO_IO_PORT_BASE 62

// ----------------------------------------
// Issue rule

// Cycles from a write to the earliest dependent read
`define OCTAVO_ISSUE_SPACING 4

`endif

// ==== rtl/octavo_pkg.sv ====
// Shared datapath types and the port address decode, referenced by scoped name from RTL and testbench
`default_nettype none

`include "octavo_cfg.svh"

package octavo_pkg;

    typedef logic [`OCTAVO_WORD_WIDTH-1:0]       word_t;
    typedef logic [`OCTAVO_ADDR_WIDTH-1:0]       mem_addr_t;
    typedef logic [`OCTAVO_WRITE_ADDR_WIDTH-1:0] write_addr_t;
    typedef logic [`OCTAVO_IO_PORT_COUNT-1:0]    port_mask_t;

    // One data word per I/O port of a bank
    typedef word_t [`OCTAVO_IO_PORT_COUNT-1:0] port_data_t;

    typedef enum logic [2:0] {
        add     = 3'd0,
        sub     = 3'd1,
        bit_and = 3'd2,
        bit_or  = 3'd3,
        bit_xor = 3'd4,
        pass_a  = 3'd5
    } alu_op_e;

    typedef struct packed {
        alu_op_e     op;
        write_addr_t d;
        mem_addr_t   a;
        mem_addr_t   b;
    } instr_t;

    // Read flags are set when data waits, write flags when there is room
    typedef struct packed {
        port_mask_t read_ef_a;
        port_mask_t read_ef_b;
        port_mask_t write_ef_a;
        port_mask_t write_ef_b;
    } io_flags_t;

    typedef struct packed {
        logic        valid;
        alu_op_e     op;
        write_addr_t d;
        word_t       data_a;
        word_t       data_b;
    } operand_t;

    typedef struct packed {
        logic        valid;
        write_addr_t d;
        word_t       value;
        logic        carry;
        logic        overflow;
    } result_t;

    typedef struct packed {
        port_mask_t wren_a;
        port_mask_t wren_b;
        word_t      data;
    } io_write_t;

    // One-hot mask of the port mapped at a bank address, zero for plain memory
    function automatic port_mask_t port_select(input mem_addr_t addr);
        port_mask_t sel;
        sel = '0;
        for (int p = 0; p < `OCTAVO_IO_PORT_COUNT; p++) begin
            if (addr == mem_addr_t'(`OCTAVO_IO_PORT_BASE + p)) begin
                sel[p] = 1'b1;
            end
        end
        return sel;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/io_predication.sv ====
// First pipeline stage: checks I/O port flags, pulses read enables and annuls blocked instructions
`timescale 1ns/1ps
`default_nettype none

`include "octavo_cfg.svh"

module io_predication (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  issue,
    input  wire octavo_pkg::instr_t    instr,
    input  wire logic                  branch_cancel,
    input  wire octavo_pkg::io_flags_t io_flags,
    output logic                       pred_valid,
    output octavo_pkg::instr_t         pred_instr,
    output logic                       io_ready,
    output octavo_pkg::port_mask_t     io_rden_a,
    output octavo_pkg::port_mask_t     io_rden_b
);

    octavo_pkg::port_mask_t read_sel_a;
    octavo_pkg::port_mask_t read_sel_b;
    octavo_pkg::port_mask_t write_sel;
    octavo_pkg::port_mask_t write_room;
    logic                   dest_bank_b;
    logic                   ready;
    logic                   annul;
    octavo_pkg::instr_t     instr_annulled;

    // ----------------------------------------
    // Port decode and readiness

    assign read_sel_a  = octavo_pkg::port_select(instr.a);
    assign read_sel_b  = octavo_pkg::port_select(instr.b);
    assign dest_bank_b = instr.d[`OCTAVO_WRITE_ADDR_WIDTH-1];
    assign write_sel   = octavo_pkg::port_select(instr.d[`OCTAVO_ADDR_WIDTH-1:0]);
    assign write_room  = dest_bank_b ? io_flags.write_ef_b : io_flags.write_ef_a;

    // Ready unless a selected port has its flag clear
    assign ready = ((read_sel_a & ~io_flags.read_ef_a) == '0)
                && ((read_sel_b & ~io_flags.read_ef_b) == '0)
                && ((write_sel & ~write_room) == '0);

    // Bubbles are annulled too, so they reach the memory as no-ops
    assign annul = !issue || !ready || branch_cancel;

    // ----------------------------------------
    // Annulment forces every address to zero

    always_comb begin
        instr_annulled = instr;
        if (annul) begin
            instr_annulled.a = '0;
            instr_annulled.b = '0;
            instr_annulled.d = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pred_valid <= 1'b0;
            io_ready   <= 1'b0;
            io_rden_a  <= '0;
            io_rden_b  <= '0;
        end else begin
            pred_valid <= issue;
            io_ready   <= issue && ready;
            io_rden_a  <= annul ? '0 : read_sel_a;
            io_rden_b  <= annul ? '0 : read_sel_b;
        end
    end

    always_ff @(posedge clock) begin
        pred_instr <= instr_annulled;
    end

    // A port is never popped on behalf of an instruction that was held back
    rden_only_when_ready: assert property (
        @(posedge clock) disable iff (reset)
        !io_ready |-> (io_rden_a == '0 && io_rden_b == '0)
    );

endmodule

`default_nettype wire

// ==== rtl/operand_memory.sv ====
// Operand banks A and B with memory-mapped I/O ports, registered operand reads and result write-back
`timescale 1ns/1ps
`default_nettype none

`include "octavo_cfg.svh"

module operand_memory (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   pred_valid,
    input  wire octavo_pkg::instr_t     pred_instr,
    input  wire octavo_pkg::port_data_t io_read_data_a,
    input  wire octavo_pkg::port_data_t io_read_data_b,
    input  wire octavo_pkg::result_t    result,
    output octavo_pkg::operand_t        operand,
    output octavo_pkg::io_write_t       io_write
);

    localparam int MEM_DEPTH = 1 << `OCTAVO_ADDR_WIDTH;

    octavo_pkg::word_t      mem_a [MEM_DEPTH];
    octavo_pkg::word_t      mem_b [MEM_DEPTH];
    octavo_pkg::word_t      read_data_a;
    octavo_pkg::word_t      read_data_b;
    octavo_pkg::mem_addr_t  write_addr;
    octavo_pkg::port_mask_t write_port;
    logic                   write_bank_b;
    logic                   write_mem;
    logic                   mem_wren_a;
    logic                   mem_wren_b;

    // Address 0 reads as zero and a port address reads the port instead of memory
    function automatic octavo_pkg::word_t select_read(
        input octavo_pkg::mem_addr_t  addr,
        input octavo_pkg::word_t      mem_word,
        input octavo_pkg::port_data_t port_data
    );
        octavo_pkg::port_mask_t sel;
        octavo_pkg::word_t      data;
        sel  = octavo_pkg::port_select(addr);
        data = (addr == '0) ? '0 : mem_word;
        for (int p = 0; p < `OCTAVO_IO_PORT_COUNT; p++) begin
            if (sel[p]) begin
                data = port_data[p];
            end
        end
        return data;
    endfunction

    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem_a[i] = '0;
            mem_b[i] = '0;
        end
    end

    // ----------------------------------------
    // Operand read, port data sampled with the rden pulse

    assign read_data_a = select_read(pred_instr.a, mem_a[pred_instr.a], io_read_data_a);
    assign read_data_b = select_read(pred_instr.b, mem_b[pred_instr.b], io_read_data_b);

    always_ff @(posedge clock) begin
        operand.valid  <= pred_valid;
        operand.op     <= pred_instr.op;
        operand.d      <= pred_instr.d;
        operand.data_a <= read_data_a;
        operand.data_b <= read_data_b;
        if (reset) begin
            operand.valid <= 1'b0;
        end
    end

    // ----------------------------------------
    // Write-back decode

    assign write_bank_b = result.d[`OCTAVO_WRITE_ADDR_WIDTH-1];
    assign write_addr   = result.d[`OCTAVO_ADDR_WIDTH-1:0];
    assign write_port   = octavo_pkg::port_select(write_addr);
    assign write_mem    = result.valid && (write_addr != '0) && (write_port == '0);
    assign mem_wren_a   = write_mem && !write_bank_b;
    assign mem_wren_b   = write_mem && write_bank_b;

    always @(posedge clock) begin
        if (mem_wren_a) begin
            mem_a[write_addr] <= result.value;
        end
        if (mem_wren_b) begin
            mem_b[write_addr] <= result.value;
        end
    end

    // Port writes come straight off the ALU result register, in step with the memory write
    always_comb begin
        io_write.wren_a = '0;
        io_write.wren_b = '0;
        io_write.data   = result.value;
        if (result.valid) begin
            if (write_bank_b) begin
                io_write.wren_b = write_port;
            end else begin
                io_write.wren_a = write_port;
            end
        end
    end

    // Word 0 is the no-op address, so it keeps its initial zero forever
    word_zero_stays_zero: assert property (
        @(posedge clock) disable iff (reset)
        mem_a[0] == '0 && mem_b[0] == '0
    );

endmodule

`default_nettype wire

// ==== rtl/triadic_alu.sv ====
// Single-stage ALU: computes the result with carry and overflow and carries the destination along
`timescale 1ns/1ps
`default_nettype none

`include "octavo_cfg.svh"

module triadic_alu (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire octavo_pkg::operand_t operand,
    output octavo_pkg::result_t       result
);

    localparam int MSB = `OCTAVO_WORD_WIDTH - 1;

    octavo_pkg::word_t value;
    logic              carry;
    logic              overflow;

    // ----------------------------------------
    // Operation

    always_comb begin
        value    = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (operand.op)
            octavo_pkg::add: begin
                {carry, value} = {1'b0, operand.data_a} + {1'b0, operand.data_b};
                overflow = (operand.data_a[MSB] == operand.data_b[MSB])
                        && (value[MSB] != operand.data_a[MSB]);
            end
            octavo_pkg::sub: begin
                // Carry reports the borrow out of the subtraction
                {carry, value} = {1'b0, operand.data_a} - {1'b0, operand.data_b};
                overflow = (operand.data_a[MSB] != operand.data_b[MSB])
                        && (value[MSB] != operand.data_a[MSB]);
            end
            octavo_pkg::bit_and: value = operand.data_a & operand.data_b;
            octavo_pkg::bit_or:  value = operand.data_a | operand.data_b;
            octavo_pkg::bit_xor: value = operand.data_a ^ operand.data_b;
            octavo_pkg::pass_a:  value = operand.data_a;
            default:             value = '0;
        endcase
    end

    // ----------------------------------------
    // Result register

    always_ff @(posedge clock) begin
        result.valid    <= operand.valid;
        result.d        <= operand.d;
        result.value    <= value;
        result.carry    <= carry;
        result.overflow <= overflow;
        if (reset) begin
            result.valid <= 1'b0;
        end
    end

    // Issued opcodes survive predication and the operand stage unchanged
    legal_opcode: assert property (
        @(posedge clock) disable iff (reset)
        operand.valid |-> operand.op inside {octavo_pkg::add, octavo_pkg::sub,
                                             octavo_pkg::bit_and, octavo_pkg::bit_or,
                                             octavo_pkg::bit_xor, octavo_pkg::pass_a}
    );

endmodule

`default_nettype wire

// ==== rtl/octavo_datapath.sv ====
// Datapath top level: predication, operand memory and ALU in a three-cycle pipeline
`timescale 1ns/1ps
`default_nettype none

module octavo_datapath (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   issue,
    input  wire octavo_pkg::instr_t     instr,
    input  wire logic                   branch_cancel,
    input  wire octavo_pkg::io_flags_t  io_flags,
    input  wire octavo_pkg::port_data_t io_read_data_a,
    input  wire octavo_pkg::port_data_t io_read_data_b,
    output wire logic                   io_ready,
    output wire octavo_pkg::port_mask_t io_rden_a,
    output wire octavo_pkg::port_mask_t io_rden_b,
    output wire octavo_pkg::io_write_t  io_write,
    output wire octavo_pkg::result_t    result
);

    wire logic                 pred_valid;
    wire octavo_pkg::instr_t   pred_instr;
    wire octavo_pkg::operand_t operand;

    // ----------------------------------------
    // Producer stage

    io_predication u_predication (
        .clock         (clock),
        .reset         (reset),
        .issue         (issue),
        .instr         (instr),
        .branch_cancel (branch_cancel),
        .io_flags      (io_flags),
        .pred_valid    (pred_valid),
        .pred_instr    (pred_instr),
        .io_ready      (io_ready),
        .io_rden_a     (io_rden_a),
        .io_rden_b     (io_rden_b)
    );

    // ----------------------------------------
    // Operand buffer, written back from the ALU result

    operand_memory u_memory (
        .clock          (clock),
        .reset          (reset),
        .pred_valid     (pred_valid),
        .pred_instr     (pred_instr),
        .io_read_data_a (io_read_data_a),
        .io_read_data_b (io_read_data_b),
        .result         (result),
        .operand        (operand),
        .io_write       (io_write)
    );

    // ----------------------------------------
    // Consumer stage

    triadic_alu u_alu (
        .clock   (clock),
        .reset   (reset),
        .operand (operand),
        .result  (result)
    );

endmodule

`default_nettype wire

// ==== verif/octavo_datapath_tb.sv ====
// Testbench top that drives the datapath from a table of rows and checks every output
`timescale 1ns/1ps
`default_nettype none

`include "octavo_cfg.svh"

module octavo_datapath_tb;

    localparam int ROWS         = 18;
    localparam int RESET_CYCLES = 10;
    localparam int LIMIT        = RESET_CYCLES + ROWS + 3 + 20;
    localparam int MEM_DEPTH    = 1 << `OCTAVO_ADDR_WIDTH;
    localparam int HALF_RANGE   = 1 << (`OCTAVO_WORD_WIDTH - 1);

    // One instruction row with its expected responses
    typedef struct packed {
        logic                   issue;
        octavo_pkg::instr_t     instr;
        logic                   cancel;
        octavo_pkg::io_flags_t  flags;
        octavo_pkg::port_data_t port_a;
        octavo_pkg::port_data_t port_b;
        logic                   exp_ready;
        octavo_pkg::port_mask_t exp_rden_a;
        octavo_pkg::port_mask_t exp_rden_b;
        octavo_pkg::result_t    exp_result;
        octavo_pkg::io_write_t  exp_io_write;
    } row_t;

    logic                   clock;
    logic                   reset;
    logic                   issue;
    octavo_pkg::instr_t     instr;
    logic                   branch_cancel;
    octavo_pkg::io_flags_t  io_flags;
    octavo_pkg::port_data_t io_read_data_a;
    octavo_pkg::port_data_t io_read_data_b;
    logic                   io_ready;
    octavo_pkg::port_mask_t io_rden_a;
    octavo_pkg::port_mask_t io_rden_b;
    octavo_pkg::io_write_t  io_write;
    octavo_pkg::result_t    result;

    row_t              rows [ROWS];
    int                n_rows = 0;
    int                seed = 82463;
    int                cycle_count = 0;
    octavo_pkg::word_t model_a [MEM_DEPTH];
    octavo_pkg::word_t model_b [MEM_DEPTH];
    // Row index of the last write to each model word
    int                written_a [MEM_DEPTH];
    int                written_b [MEM_DEPTH];

    octavo_datapath uut (
        .clock          (clock),
        .reset          (reset),
        .issue          (issue),
        .instr          (instr),
        .branch_cancel  (branch_cancel),
        .io_flags       (io_flags),
        .io_read_data_a (io_read_data_a),
        .io_read_data_b (io_read_data_b),
        .io_ready       (io_ready),
        .io_rden_a      (io_rden_a),
        .io_rden_b      (io_rden_b),
        .io_write       (io_write),
        .result         (result)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            stop_with_failure();
        end
    end

    // ----------------------------------------
    // Compare tasks

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_mask(input string name, input octavo_pkg::port_mask_t got,
                              input octavo_pkg::port_mask_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_result(input string name, input octavo_pkg::result_t got,
                                input octavo_pkg::result_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Write data only matters when some port is written
    task automatic check_io_write(input string name, input octavo_pkg::io_write_t got,
                                  input octavo_pkg::io_write_t exp);
        logic writing;
        writing = (exp.wren_a != '0) || (exp.wren_b != '0);
        if (got.wren_a !== exp.wren_a || got.wren_b !== exp.wren_b
                || (writing && got.data !== exp.data)) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // ----------------------------------------
    // Reference model of the address map and ALU

    function automatic int port_index(input octavo_pkg::mem_addr_t addr);
        int offset;
        offset = int'(addr) - `OCTAVO_IO_PORT_BASE;
        if (offset >= 0 && offset < `OCTAVO_IO_PORT_COUNT) return offset;
        return -1;
    endfunction

    function automatic octavo_pkg::word_t model_read(input logic bank_b,
                                                     input octavo_pkg::mem_addr_t addr,
                                                     input octavo_pkg::port_data_t ports);
        int p;
        p = port_index(addr);
        if (addr == '0) return '0;
        if (p >= 0) return ports[p];
        return bank_b ? model_b[addr] : model_a[addr];
    endfunction

    task automatic alu_model(input octavo_pkg::alu_op_e op, input octavo_pkg::word_t a,
                             input octavo_pkg::word_t b, output octavo_pkg::word_t value,
                             output logic carry, output logic overflow);
        int sa;
        int sb;
        int wide;
        sa       = int'($signed(a));
        sb       = int'($signed(b));
        value    = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (op)
            octavo_pkg::add: begin
                value    = a + b;
                carry    = value < a;
                wide     = sa + sb;
                overflow = (wide >= HALF_RANGE) || (wide < -HALF_RANGE);
            end
            octavo_pkg::sub: begin
                // Carry is the borrow
                value    = a - b;
                carry    = a < b;
                wide     = sa - sb;
                overflow = (wide >= HALF_RANGE) || (wide < -HALF_RANGE);
            end
            octavo_pkg::bit_and: value = a & b;
            octavo_pkg::bit_or:  value = a | b;
            octavo_pkg::bit_xor: value = a ^ b;
            octavo_pkg::pass_a:  value = a;
            default:             value = '0;
        endcase
    endtask

    // Rows keep the issue spacing, so the model can retire them one at a time in order
    task automatic predict_rows();
        row_t                   r;
        int                     pa;
        int                     pb;
        int                     pd;
        logic                   ready;
        logic                   annul;
        octavo_pkg::port_mask_t room;
        octavo_pkg::instr_t     eff;
        octavo_pkg::word_t      data_a;
        octavo_pkg::word_t      data_b;
        octavo_pkg::word_t      value;
        logic                   carry;
        logic                   overflow;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            model_a[i]   = '0;
            model_b[i]   = '0;
            written_a[i] = -`OCTAVO_ISSUE_SPACING;
            written_b[i] = -`OCTAVO_ISSUE_SPACING;
        end
        for (int i = 0; i < n_rows; i++) begin
            r     = rows[i];
            pa    = port_index(r.instr.a);
            pb    = port_index(r.instr.b);
            pd    = port_index(r.instr.d[`OCTAVO_ADDR_WIDTH-1:0]);
            room  = r.instr.d[`OCTAVO_WRITE_ADDR_WIDTH-1] ? r.flags.write_ef_b
                                                          : r.flags.write_ef_a;
            ready = 1'b1;
            if (pa >= 0 && !r.flags.read_ef_a[pa]) ready = 1'b0;
            if (pb >= 0 && !r.flags.read_ef_b[pb]) ready = 1'b0;
            if (pd >= 0 && !room[pd]) ready = 1'b0;
            annul = !r.issue || !ready || r.cancel;
            eff   = r.instr;
            if (annul) begin
                eff.a = '0;
                eff.b = '0;
                eff.d = '0;
            end
            if (eff.a != '0 && pa < 0 && i - written_a[eff.a] < `OCTAVO_ISSUE_SPACING) begin
                $display("table row %0d reads a bank A word written too few rows before", i);
                stop_with_failure();
            end
            if (eff.b != '0 && pb < 0 && i - written_b[eff.b] < `OCTAVO_ISSUE_SPACING) begin
                $display("table row %0d reads a bank B word written too few rows before", i);
                stop_with_failure();
            end
            r.exp_ready  = r.issue && ready;
            r.exp_rden_a = '0;
            r.exp_rden_b = '0;
            if (!annul && pa >= 0) r.exp_rden_a[pa] = 1'b1;
            if (!annul && pb >= 0) r.exp_rden_b[pb] = 1'b1;
            data_a = model_read(1'b0, eff.a, r.port_a);
            data_b = model_read(1'b1, eff.b, r.port_b);
            alu_model(eff.op, data_a, data_b, value, carry, overflow);
            r.exp_result.valid    = r.issue;
            r.exp_result.d        = eff.d;
            r.exp_result.value    = value;
            r.exp_result.carry    = carry;
            r.exp_result.overflow = overflow;
            r.exp_io_write        = '0;
            r.exp_io_write.data   = value;
            pd = port_index(eff.d[`OCTAVO_ADDR_WIDTH-1:0]);
            if (r.issue && eff.d[`OCTAVO_ADDR_WIDTH-1:0] != '0) begin
                if (pd >= 0 && eff.d[`OCTAVO_WRITE_ADDR_WIDTH-1]) begin
                    r.exp_io_write.wren_b[pd] = 1'b1;
                end else if (pd >= 0) begin
                    r.exp_io_write.wren_a[pd] = 1'b1;
                end else if (eff.d[`OCTAVO_WRITE_ADDR_WIDTH-1]) begin
                    model_b[eff.d[`OCTAVO_ADDR_WIDTH-1:0]]   = value;
                    written_b[eff.d[`OCTAVO_ADDR_WIDTH-1:0]] = i;
                end else begin
                    model_a[eff.d[`OCTAVO_ADDR_WIDTH-1:0]]   = value;
                    written_a[eff.d[`OCTAVO_ADDR_WIDTH-1:0]] = i;
                end
            end
            rows[i] = r;
        end
    endtask

    // ----------------------------------------
    // Stimulus table

    task automatic add_row(input logic issue_bit, input octavo_pkg::alu_op_e op,
                           input int d, input int a, input int b, input logic cancel,
                           input logic [7:0] flags);
        row_t r;
        r          = '0;
        r.issue    = issue_bit;
        r.instr.op = op;
        r.instr.d  = octavo_pkg::write_addr_t'(d);
        r.instr.a  = octavo_pkg::mem_addr_t'(a);
        r.instr.b  = octavo_pkg::mem_addr_t'(b);
        r.cancel   = cancel;
        r.flags    = octavo_pkg::io_flags_t'(flags);
        for (int p = 0; p < `OCTAVO_IO_PORT_COUNT; p++) begin
            r.port_a[p] = octavo_pkg::word_t'($random(seed));
            r.port_b[p] = octavo_pkg::word_t'($random(seed));
        end
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic build_table();
        // Port reads stored with pass_a, issued back to back
        add_row(1'b1, octavo_pkg::pass_a, 1, 62, 0, 1'b0, 8'hFF);
        add_row(1'b1, octavo_pkg::pass_a, 65, 63, 62, 1'b0, 8'hFF);
        add_row(1'b1, octavo_pkg::pass_a, 2, 62, 0, 1'b0, 8'hFF);
        add_row(1'b1, octavo_pkg::pass_a, 66, 63, 63, 1'b0, 8'hFF);
        // Empty read port, full write port, then a cancelled instruction
        add_row(1'b1, octavo_pkg::pass_a, 10, 62, 0, 1'b0, 8'h3F);
        add_row(1'b1, octavo_pkg::add, 126, 0, 0, 1'b0, 8'hFC);
        add_row(1'b1, octavo_pkg::pass_a, 11, 63, 0, 1'b1, 8'hFF);
        // Every opcode on stored words, and one OR that takes its B operand from port B0
        add_row(1'b1, octavo_pkg::add, 3, 2, 2, 1'b0, 8'hFF);
        add_row(1'b1, octavo_pkg::sub, 67, 2, 2, 1'b0, 8'hFF);
        add_row(1'b1, octavo_pkg::bit_and, 4, 1, 1, 1'b0, 8'hFF);
        add_row(1'b1, octavo_pkg::bit_or, 5, 1, 62, 1'b0, 8'hFF);
        add_row(1'b1, octavo_pkg::bit_xor, 68, 2, 1, 1'b0, 8'hFF);
        // Writes to port A0 and port B1
        add_row(1'b1, octavo_pkg::pass_a, 62, 3, 0, 1'b0, 8'hFF);
        add_row(1'b1, octavo_pkg::sub, 127, 1, 1, 1'b0, 8'hFF);
        // Read-backs of annulled destinations and the add result, then one more port A0 read
        add_row(1'b1, octavo_pkg::bit_or, 12, 10, 0, 1'b0, 8'hFF);
        add_row(1'b1, octavo_pkg::pass_a, 13, 11, 0, 1'b0, 8'hFF);
        add_row(1'b1, octavo_pkg::add, 15, 3, 3, 1'b0, 8'hFF);
        add_row(1'b1, octavo_pkg::pass_a, 14, 62, 0, 1'b0, 8'hFF);
        // Fixed words make the add carry and the sub overflow
        rows[2].port_a[0] = 16'hC000;
        rows[3].port_a[1] = 16'h5000;
        predict_rows();
    endtask

    task automatic drive_row(input row_t r);
        issue         = r.issue;
        instr         = r.instr;
        branch_cancel = r.cancel;
        io_flags      = r.flags;
    endtask

    // ----------------------------------------
    // Run

    initial begin
        reset          = 1'b1;
        drive_row('0);
        io_read_data_a = '0;
        io_read_data_b = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_bit("io_ready after reset", io_ready, 1'b0);
        check_mask("io_rden_a after reset", io_rden_a, '0);
        check_mask("io_rden_b after reset", io_rden_b, '0);
        check_mask("io_write.wren_a after reset", io_write.wren_a, '0);
        check_mask("io_write.wren_b after reset", io_write.wren_b, '0);
        check_bit("result.valid after reset", result.valid, 1'b0);

        // Predication answers one cycle after issue, the result three cycles after
        for (int k = 0; k < ROWS + 3; k++) begin
            @(negedge clock);
            if (k >= 1 && k <= ROWS) begin
                check_bit($sformatf("io_ready row %0d", k - 1), io_ready, rows[k-1].exp_ready);
                check_mask($sformatf("io_rden_a row %0d", k - 1), io_rden_a,
                           rows[k-1].exp_rden_a);
                check_mask($sformatf("io_rden_b row %0d", k - 1), io_rden_b,
                           rows[k-1].exp_rden_b);
            end
            if (k >= 3) begin
                check_result($sformatf("result row %0d", k - 3), result, rows[k-3].exp_result);
                check_io_write($sformatf("io_write row %0d", k - 3), io_write,
                               rows[k-3].exp_io_write);
            end
            if (k < ROWS) begin
                drive_row(rows[k]);
            end else begin
                drive_row('0);
            end
            // Port data is presented in the cycle of the rden pulse
            if (k >= 1 && k <= ROWS) begin
                io_read_data_a = rows[k-1].port_a;
                io_read_data_b = rows[k-1].port_b;
            end else begin
                io_read_data_a = '0;
                io_read_data_b = '0;
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== octavo_datapath.f ====
+incdir+rtl
rtl/octavo_pkg.sv
rtl/io_predication.sv
rtl/operand_memory.sv
rtl/triadic_alu.sv
rtl/octavo_datapath.sv
verif/octavo_datapath_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the datapath testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f octavo_datapath.f \
    --top-module octavo_datapath_tb -o octavo_sim &&
./obj_dir/octavo_sim | tee /dev/stderr | grep -qx "sim passed" &&
echo "run_sim: testbench passed" ||
{ echo "run_sim: testbench failed or did not build"; exit 1; }
